// ==== design/acc_dma_pkg.sv ====
`default_nettype none

package acc_dma_pkg;

   localparam int beat_w = 64;
   localparam int word_w = 32;   // Even word in low half, odd word in high half
   localparam int addr_w = 16;
   localparam int be_w   = 4;

   // Size code for 32-bit elements
   localparam logic [2:0] dma_size_word = 3'd2;

   typedef enum logic [3:0] {
      PH_IDLE,
      PH_W_REQ,
      PH_W_LOAD,
      PH_A_REQ,
      PH_A_LOAD,
      PH_START,
      PH_COMPUTE,
      PH_WB_REQ,
      PH_WB_SEND,
      PH_DONE
   } dma_phase_t;

endpackage

`default_nettype wire

// ==== design/dual_port_sram.sv ====
`timescale 1ns/100ps
`default_nettype none

module dual_port_sram #(
   parameter int depth = 64
) (
   input  wire logic                             clk,
   input  wire logic [acc_dma_pkg::be_w-1:0]     be0,
   input  wire logic [acc_dma_pkg::addr_w-1:0]   addr0,
   input  wire logic [acc_dma_pkg::word_w-1:0]   wdata0,
   output logic      [acc_dma_pkg::word_w-1:0]   rdata0,
   input  wire logic [acc_dma_pkg::be_w-1:0]     be1,
   input  wire logic [acc_dma_pkg::addr_w-1:0]   addr1,
   input  wire logic [acc_dma_pkg::word_w-1:0]   wdata1,
   output logic      [acc_dma_pkg::word_w-1:0]   rdata1
);

   localparam int aw = $clog2(depth);

   logic [acc_dma_pkg::word_w-1:0] mem [depth];

   // Port 1 wins on a same-byte collision
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < acc_dma_pkg::be_w; b++)
      begin
         if (be0[b])
            mem[addr0[aw-1:0]][8*b +: 8] <= wdata0[8*b +: 8];
         if (be1[b])
            mem[addr1[aw-1:0]][8*b +: 8] <= wdata1[8*b +: 8];
      end
   end

   ////////////////////////////////////////////////////
   // One-cycle registered read
   always_ff @(posedge clk)
   begin
      rdata0 <= mem[addr0[aw-1:0]];
      rdata1 <= mem[addr1[aw-1:0]];
   end

endmodule

`default_nettype wire

// ==== design/dma_phase_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_phase_fsm #(
   parameter int w_index  = 0,
   parameter int w_beats  = 16,
   parameter int a_index  = 1000,
   parameter int a_beats  = 8,
   parameter int wb_index = 1008,
   parameter int wb_beats = 6
) (
   input  wire logic               clk,
   input  wire logic               rst,
   input  wire logic               conf_done,
   input  wire logic               dma_read_ctrl_ready,
   input  wire logic               dma_write_ctrl_ready,
   input  wire logic               load_last,
   input  wire logic               send_last,
   input  wire logic               compute_finish,
   output acc_dma_pkg::dma_phase_t phase,
   output logic                    dma_read_ctrl_valid,
   output logic [31:0]             dma_read_ctrl_data_index,
   output logic [31:0]             dma_read_ctrl_data_length,
   output logic [2:0]              dma_read_ctrl_data_size,
   output logic                    dma_write_ctrl_valid,
   output logic [31:0]             dma_write_ctrl_data_index,
   output logic [31:0]             dma_write_ctrl_data_length,
   output logic [2:0]              dma_write_ctrl_data_size,
   output logic                    dma_read_chnl_ready,
   output logic                    compute_start,
   output logic                    acc_done
);

   acc_dma_pkg::dma_phase_t phase_n;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         phase         <= acc_dma_pkg::PH_IDLE;
         compute_start <= 1'b0;
      end
      else
      begin
         phase         <= phase_n;
         compute_start <= (phase == acc_dma_pkg::PH_START);  // Lands in first compute cycle
      end
   end

   always_comb
   begin
      phase_n = phase;
      case (phase)
         acc_dma_pkg::PH_IDLE:    if (conf_done) phase_n = acc_dma_pkg::PH_W_REQ;
         acc_dma_pkg::PH_W_REQ:   if (dma_read_ctrl_ready) phase_n = acc_dma_pkg::PH_W_LOAD;
         acc_dma_pkg::PH_W_LOAD:  if (load_last) phase_n = acc_dma_pkg::PH_A_REQ;
         acc_dma_pkg::PH_A_REQ:   if (dma_read_ctrl_ready) phase_n = acc_dma_pkg::PH_A_LOAD;
         acc_dma_pkg::PH_A_LOAD:  if (load_last) phase_n = acc_dma_pkg::PH_START;
         acc_dma_pkg::PH_START:   phase_n = acc_dma_pkg::PH_COMPUTE;
         acc_dma_pkg::PH_COMPUTE: if (compute_finish) phase_n = acc_dma_pkg::PH_WB_REQ;
         acc_dma_pkg::PH_WB_REQ:  if (dma_write_ctrl_ready) phase_n = acc_dma_pkg::PH_WB_SEND;
         acc_dma_pkg::PH_WB_SEND: if (send_last) phase_n = acc_dma_pkg::PH_DONE;
         default:                 phase_n = acc_dma_pkg::PH_IDLE;
      endcase
   end

   //////////////////////////////////////////////////
   // Control requests held by the phase until ready
   always_comb
   begin
      dma_read_ctrl_valid       = 1'b0;
      dma_read_ctrl_data_index  = '0;
      dma_read_ctrl_data_length = '0;
      dma_read_ctrl_data_size   = '0;
      if (phase == acc_dma_pkg::PH_W_REQ)
      begin
         dma_read_ctrl_valid       = 1'b1;
         dma_read_ctrl_data_index  = 32'(w_index);
         dma_read_ctrl_data_length = 32'(2 * w_beats);   // Length in words
         dma_read_ctrl_data_size   = acc_dma_pkg::dma_size_word;
      end
      else if (phase == acc_dma_pkg::PH_A_REQ)
      begin
         dma_read_ctrl_valid       = 1'b1;
         dma_read_ctrl_data_index  = 32'(a_index);
         dma_read_ctrl_data_length = 32'(2 * a_beats);
         dma_read_ctrl_data_size   = acc_dma_pkg::dma_size_word;
      end
   end

   always_comb
   begin
      dma_write_ctrl_valid       = (phase == acc_dma_pkg::PH_WB_REQ);
      dma_write_ctrl_data_index  = '0;
      dma_write_ctrl_data_length = '0;
      dma_write_ctrl_data_size   = '0;
      if (dma_write_ctrl_valid)
      begin
         dma_write_ctrl_data_index  = 32'(wb_index);
         dma_write_ctrl_data_length = 32'(2 * wb_beats);
         dma_write_ctrl_data_size   = acc_dma_pkg::dma_size_word;
      end
   end

   assign dma_read_chnl_ready = (phase == acc_dma_pkg::PH_W_LOAD) ||
                                (phase == acc_dma_pkg::PH_A_LOAD);
   assign acc_done            = (phase == acc_dma_pkg::PH_DONE);

endmodule

`default_nettype wire

// ==== design/buffer_access_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module buffer_access_ctrl #(
   parameter int w_beats  = 16,
   parameter int a_beats  = 8,
   parameter int wb_beats = 6
) (
   input  wire logic                             clk,
   input  wire logic                             rst,
   input  wire acc_dma_pkg::dma_phase_t          phase,
   input  wire logic                             dma_read_chnl_valid,
   input  wire logic                             dma_read_chnl_ready,
   input  wire logic [acc_dma_pkg::beat_w-1:0]   dma_read_chnl_data,
   input  wire logic                             wb_accept,
   input  wire logic [acc_dma_pkg::addr_w-1:0]   eng_w_addr0,
   input  wire logic [acc_dma_pkg::addr_w-1:0]   eng_w_addr1,
   input  wire logic [acc_dma_pkg::addr_w-1:0]   eng_a_addr0,
   input  wire logic [acc_dma_pkg::addr_w-1:0]   eng_a_addr1,
   input  wire logic [acc_dma_pkg::be_w-1:0]     eng_a_we0,
   input  wire logic [acc_dma_pkg::be_w-1:0]     eng_a_we1,
   input  wire logic [acc_dma_pkg::word_w-1:0]   eng_a_wdata0,
   input  wire logic [acc_dma_pkg::word_w-1:0]   eng_a_wdata1,
   output logic      [acc_dma_pkg::addr_w-1:0]   w_addr0,
   output logic      [acc_dma_pkg::addr_w-1:0]   w_addr1,
   output logic      [acc_dma_pkg::be_w-1:0]     w_be0,
   output logic      [acc_dma_pkg::be_w-1:0]     w_be1,
   output logic      [acc_dma_pkg::word_w-1:0]   w_wdata0,
   output logic      [acc_dma_pkg::word_w-1:0]   w_wdata1,
   output logic      [acc_dma_pkg::addr_w-1:0]   a_addr0,
   output logic      [acc_dma_pkg::addr_w-1:0]   a_addr1,
   output logic      [acc_dma_pkg::be_w-1:0]     a_be0,
   output logic      [acc_dma_pkg::be_w-1:0]     a_be1,
   output logic      [acc_dma_pkg::word_w-1:0]   a_wdata0,
   output logic      [acc_dma_pkg::word_w-1:0]   a_wdata1,
   output logic                                  load_last,
   output logic                                  send_last
);

   localparam int aw = acc_dma_pkg::addr_w;
   localparam int ww = acc_dma_pkg::word_w;

   // Word address of the last beat of each transfer
   localparam logic [aw-1:0] w_last  = aw'(2 * (w_beats - 1));
   localparam logic [aw-1:0] a_last  = aw'(2 * (a_beats - 1));
   localparam logic [aw-1:0] wb_last = aw'(2 * (a_beats + wb_beats - 1));  // After inputs

   logic [aw-1:0] w_ptr;
   logic [aw-1:0] a_ptr;
   logic          w_fire;
   logic          a_fire;

   assign w_fire = dma_read_chnl_valid && dma_read_chnl_ready &&
                   (phase == acc_dma_pkg::PH_W_LOAD);
   assign a_fire = dma_read_chnl_valid && dma_read_chnl_ready &&
                   (phase == acc_dma_pkg::PH_A_LOAD);

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         w_ptr <= '0;
         a_ptr <= '0;
      end
      else if (phase == acc_dma_pkg::PH_IDLE)
      begin
         w_ptr <= '0;
         a_ptr <= '0;
      end
      else
      begin
         if (w_fire)
            w_ptr <= w_ptr + aw'(2);
         if (a_fire || wb_accept)
            a_ptr <= a_ptr + aw'(2);   // Runs on into write-back
      end
   end

   assign load_last = (w_fire && (w_ptr == w_last)) || (a_fire && (a_ptr == a_last));
   assign send_last = wb_accept && (a_ptr == wb_last);

   //////////////////////////////////////////////////
   // Engine owns both RAMs in compute
   always_comb
   begin
      w_addr0  = w_ptr;
      w_addr1  = w_ptr + 1'b1;
      w_be0    = {acc_dma_pkg::be_w{w_fire}};
      w_be1    = {acc_dma_pkg::be_w{w_fire}};
      w_wdata0 = dma_read_chnl_data[ww-1:0];
      w_wdata1 = dma_read_chnl_data[2*ww-1:ww];
      a_addr0  = a_ptr;
      a_addr1  = a_ptr + 1'b1;
      a_be0    = {acc_dma_pkg::be_w{a_fire}};
      a_be1    = {acc_dma_pkg::be_w{a_fire}};
      a_wdata0 = dma_read_chnl_data[ww-1:0];
      a_wdata1 = dma_read_chnl_data[2*ww-1:ww];
      if (phase == acc_dma_pkg::PH_COMPUTE)
      begin
         w_addr0  = eng_w_addr0;   // Read only for the engine
         w_addr1  = eng_w_addr1;
         a_addr0  = eng_a_addr0;
         a_addr1  = eng_a_addr1;
         a_be0    = eng_a_we0;
         a_be1    = eng_a_we1;
         a_wdata0 = eng_a_wdata0;
         a_wdata1 = eng_a_wdata1;
      end
   end

endmodule

`default_nettype wire

// ==== design/writeback_streamer.sv ====
`timescale 1ns/100ps
`default_nettype none

module writeback_streamer (
   input  wire logic                             clk,
   input  wire logic                             rst,
   input  wire acc_dma_pkg::dma_phase_t          phase,
   input  wire logic [acc_dma_pkg::word_w-1:0]   a_rdata0,
   input  wire logic [acc_dma_pkg::word_w-1:0]   a_rdata1,
   input  wire logic                             dma_write_chnl_ready,
   output logic                                  dma_write_chnl_valid,
   output logic      [acc_dma_pkg::beat_w-1:0]   dma_write_chnl_data,
   output logic                                  wb_accept
);

   logic                            held;
   logic [acc_dma_pkg::beat_w-1:0] beat_q;
   logic [acc_dma_pkg::beat_w-1:0] fresh_beat;

   assign fresh_beat = {a_rdata1, a_rdata0};   // Odd word high
   assign wb_accept  = dma_write_chnl_valid && dma_write_chnl_ready;

   // Later valid cycles replay the captured beat
   assign dma_write_chnl_data = held ? beat_q : fresh_beat;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         dma_write_chnl_valid <= 1'b0;
         held                 <= 1'b0;
      end
      else if (phase != acc_dma_pkg::PH_WB_SEND)
      begin
         dma_write_chnl_valid <= 1'b0;
         held                 <= 1'b0;
      end
      else
      begin
         dma_write_chnl_valid <= !wb_accept;   // One idle cycle per beat for the read
         held                 <= dma_write_chnl_valid && !wb_accept;
      end
   end

   always_ff @(posedge clk)
   begin
      if (dma_write_chnl_valid && !held)
         beat_q <= fresh_beat;
   end

endmodule

`default_nettype wire

// ==== design/acc_dma_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module acc_dma_top #(
   parameter int w_index  = 0,
   parameter int w_beats  = 16,     // 7880 on the full network
   parameter int a_index  = 1000,
   parameter int a_beats  = 8,      // 128 on the full network
   parameter int wb_index = 1008,
   parameter int wb_beats = 6,      // 249 on the full network
   parameter int w_depth  = 64,
   parameter int a_depth  = 64
) (
   input  wire logic                             clk,
   input  wire logic                             rst,
   input  wire logic                             conf_done,
   output logic                                  acc_done,
   output logic                                  compute_start,
   input  wire logic                             compute_finish,
   // DMA read
   output logic                                  dma_read_ctrl_valid,
   output logic      [31:0]                      dma_read_ctrl_data_index,
   output logic      [31:0]                      dma_read_ctrl_data_length,
   output logic      [2:0]                       dma_read_ctrl_data_size,
   input  wire logic                             dma_read_ctrl_ready,
   input  wire logic                             dma_read_chnl_valid,
   input  wire logic [acc_dma_pkg::beat_w-1:0]   dma_read_chnl_data,
   output logic                                  dma_read_chnl_ready,
   // DMA write
   output logic                                  dma_write_ctrl_valid,
   output logic      [31:0]                      dma_write_ctrl_data_index,
   output logic      [31:0]                      dma_write_ctrl_data_length,
   output logic      [2:0]                       dma_write_ctrl_data_size,
   input  wire logic                             dma_write_ctrl_ready,
   output logic                                  dma_write_chnl_valid,
   output logic      [acc_dma_pkg::beat_w-1:0]   dma_write_chnl_data,
   input  wire logic                             dma_write_chnl_ready,
   // Engine side
   input  wire logic [acc_dma_pkg::addr_w-1:0]   eng_w_addr0,
   input  wire logic [acc_dma_pkg::addr_w-1:0]   eng_w_addr1,
   output logic      [acc_dma_pkg::word_w-1:0]   eng_w_rdata0,
   output logic      [acc_dma_pkg::word_w-1:0]   eng_w_rdata1,
   input  wire logic [acc_dma_pkg::addr_w-1:0]   eng_a_addr0,
   input  wire logic [acc_dma_pkg::addr_w-1:0]   eng_a_addr1,
   input  wire logic [acc_dma_pkg::be_w-1:0]     eng_a_we0,
   input  wire logic [acc_dma_pkg::be_w-1:0]     eng_a_we1,
   input  wire logic [acc_dma_pkg::word_w-1:0]   eng_a_wdata0,
   input  wire logic [acc_dma_pkg::word_w-1:0]   eng_a_wdata1,
   output logic      [acc_dma_pkg::word_w-1:0]   eng_a_rdata0,
   output logic      [acc_dma_pkg::word_w-1:0]   eng_a_rdata1
);

   acc_dma_pkg::dma_phase_t phase;

   logic                           load_last;
   logic                           send_last;
   logic                           wb_accept;
   logic [acc_dma_pkg::addr_w-1:0] w_addr0, w_addr1, a_addr0, a_addr1;
   logic [acc_dma_pkg::be_w-1:0]   w_be0, w_be1, a_be0, a_be1;
   logic [acc_dma_pkg::word_w-1:0] w_wdata0, w_wdata1, a_wdata0, a_wdata1;

   //////////////////////////////////////////////////
   dma_phase_fsm #(
      .w_index(w_index), .w_beats(w_beats), .a_index(a_index),
      .a_beats(a_beats), .wb_index(wb_index), .wb_beats(wb_beats)
   ) u_fsm (
      .clk(clk), .rst(rst), .conf_done(conf_done),
      .dma_read_ctrl_ready(dma_read_ctrl_ready), .dma_write_ctrl_ready(dma_write_ctrl_ready),
      .load_last(load_last), .send_last(send_last), .compute_finish(compute_finish),
      .phase(phase),
      .dma_read_ctrl_valid(dma_read_ctrl_valid),
      .dma_read_ctrl_data_index(dma_read_ctrl_data_index),
      .dma_read_ctrl_data_length(dma_read_ctrl_data_length),
      .dma_read_ctrl_data_size(dma_read_ctrl_data_size),
      .dma_write_ctrl_valid(dma_write_ctrl_valid),
      .dma_write_ctrl_data_index(dma_write_ctrl_data_index),
      .dma_write_ctrl_data_length(dma_write_ctrl_data_length),
      .dma_write_ctrl_data_size(dma_write_ctrl_data_size),
      .dma_read_chnl_ready(dma_read_chnl_ready),
      .compute_start(compute_start), .acc_done(acc_done)
   );

   buffer_access_ctrl #(
      .w_beats(w_beats), .a_beats(a_beats), .wb_beats(wb_beats)
   ) u_buf (
      .clk(clk), .rst(rst), .phase(phase),
      .dma_read_chnl_valid(dma_read_chnl_valid), .dma_read_chnl_ready(dma_read_chnl_ready),
      .dma_read_chnl_data(dma_read_chnl_data), .wb_accept(wb_accept),
      .eng_w_addr0(eng_w_addr0), .eng_w_addr1(eng_w_addr1),
      .eng_a_addr0(eng_a_addr0), .eng_a_addr1(eng_a_addr1),
      .eng_a_we0(eng_a_we0), .eng_a_we1(eng_a_we1),
      .eng_a_wdata0(eng_a_wdata0), .eng_a_wdata1(eng_a_wdata1),
      .w_addr0(w_addr0), .w_addr1(w_addr1), .w_be0(w_be0), .w_be1(w_be1),
      .w_wdata0(w_wdata0), .w_wdata1(w_wdata1),
      .a_addr0(a_addr0), .a_addr1(a_addr1), .a_be0(a_be0), .a_be1(a_be1),
      .a_wdata0(a_wdata0), .a_wdata1(a_wdata1),
      .load_last(load_last), .send_last(send_last)
   );

   writeback_streamer u_wb (
      .clk(clk), .rst(rst), .phase(phase),
      .a_rdata0(eng_a_rdata0), .a_rdata1(eng_a_rdata1),   // Shared with engine read data
      .dma_write_chnl_ready(dma_write_chnl_ready),
      .dma_write_chnl_valid(dma_write_chnl_valid),
      .dma_write_chnl_data(dma_write_chnl_data),
      .wb_accept(wb_accept)
   );

   // Weight and activation buffers
   dual_port_sram #(.depth(w_depth)) u_w_ram (
      .clk(clk),
      .be0(w_be0), .addr0(w_addr0), .wdata0(w_wdata0), .rdata0(eng_w_rdata0),
      .be1(w_be1), .addr1(w_addr1), .wdata1(w_wdata1), .rdata1(eng_w_rdata1)
   );

   dual_port_sram #(.depth(a_depth)) u_a_ram (
      .clk(clk),
      .be0(a_be0), .addr0(a_addr0), .wdata0(a_wdata0), .rdata0(eng_a_rdata0),
      .be1(a_be1), .addr1(a_addr1), .wdata1(a_wdata1), .rdata1(eng_a_rdata1)
   );

endmodule

`default_nettype wire

// ==== verif/acc_dma_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module acc_dma_assertions (
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic        dma_read_ctrl_valid,
   input  wire logic        dma_read_ctrl_ready,
   input  wire logic [31:0] dma_read_ctrl_data_index,
   input  wire logic        dma_write_ctrl_valid,
   input  wire logic        dma_write_ctrl_ready,
   input  wire logic [31:0] dma_write_ctrl_data_index,
   input  wire logic        compute_start,
   input  wire logic        acc_done
);

   int violations = 0;   // Failed assertion count

   ctrl_exclusive: assert property (@(posedge clk) disable iff (!rst)
      !(dma_read_ctrl_valid && dma_write_ctrl_valid))
   else
   begin
      violations++;
      $error("read and write control requests are valid together");
   end

   read_held: assert property (@(posedge clk) disable iff (!rst)
      (dma_read_ctrl_valid && !dma_read_ctrl_ready) |=>
         (dma_read_ctrl_valid && $stable(dma_read_ctrl_data_index)))
   else
   begin
      violations++;
      $error("read control request changed before ready");
   end

   write_held: assert property (@(posedge clk) disable iff (!rst)
      (dma_write_ctrl_valid && !dma_write_ctrl_ready) |=>
         (dma_write_ctrl_valid && $stable(dma_write_ctrl_data_index)))
   else
   begin
      violations++;
      $error("write control request changed before ready");
   end

   ////////////////////////////////////////////////////
   // Single-cycle pulses
   start_pulse: assert property (@(posedge clk) disable iff (!rst)
      compute_start |=> !compute_start)
   else
   begin
      violations++;
      $error("compute_start high for more than one cycle");
   end

   done_pulse: assert property (@(posedge clk) disable iff (!rst)
      acc_done |=> !acc_done)
   else
   begin
      violations++;
      $error("acc_done high for more than one cycle");
   end

endmodule

`default_nettype wire

// ==== verif/tb_acc_dma.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_acc_dma;

   localparam int w_index  = 0;
   localparam int w_beats  = 16;
   localparam int a_index  = 1000;
   localparam int a_beats  = 8;
   localparam int wb_index = 1008;
   localparam int wb_beats = 6;
   localparam int n_runs   = 4;
   localparam int limit    = 300;   // Cycles per wait

   logic        clk;
   logic        rst;
   logic        conf_done;
   logic        acc_done;
   logic        compute_start;
   logic        compute_finish;
   logic        dma_read_ctrl_valid;
   logic [31:0] dma_read_ctrl_data_index;
   logic [31:0] dma_read_ctrl_data_length;
   logic [2:0]  dma_read_ctrl_data_size;
   logic        dma_read_ctrl_ready;
   logic        dma_read_chnl_valid;
   logic [63:0] dma_read_chnl_data;
   logic        dma_read_chnl_ready;
   logic        dma_write_ctrl_valid;
   logic [31:0] dma_write_ctrl_data_index;
   logic [31:0] dma_write_ctrl_data_length;
   logic [2:0]  dma_write_ctrl_data_size;
   logic        dma_write_ctrl_ready;
   logic        dma_write_chnl_valid;
   logic [63:0] dma_write_chnl_data;
   logic        dma_write_chnl_ready;
   logic [15:0] eng_w_addr0, eng_w_addr1, eng_a_addr0, eng_a_addr1;
   logic [3:0]  eng_a_we0, eng_a_we1;
   logic [31:0] eng_a_wdata0, eng_a_wdata1;
   logic [31:0] eng_w_rdata0, eng_w_rdata1, eng_a_rdata0, eng_a_rdata1;

   // Per run: control stall %, read gap %, write stall %, result key
   int          ctrl_stall [n_runs] = '{0, 30, 60, 85};
   int          read_gap   [n_runs] = '{0, 40, 70, 20};
   int          wr_stall   [n_runs] = '{0, 50, 20, 80};
   logic [31:0] result_key [n_runs] = '{32'h8000_0001, 32'hffff_ffff,
                                        32'h5a5a_a5a5, 32'h1357_9bdf};

   logic [31:0] w_words [2*w_beats];   // DRAM weight image
   logic [31:0] a_words [2*a_beats];
   logic [31:0] r_words [2*wb_beats];  // Engine results
   int          errors;
   int          checks;
   int          starts;
   int          dones;

   acc_dma_top dut0 (.*);

   bind dma_phase_fsm acc_dma_assertions u_assert (
      .clk(clk), .rst(rst),
      .dma_read_ctrl_valid(dma_read_ctrl_valid), .dma_read_ctrl_ready(dma_read_ctrl_ready),
      .dma_read_ctrl_data_index(dma_read_ctrl_data_index),
      .dma_write_ctrl_valid(dma_write_ctrl_valid), .dma_write_ctrl_ready(dma_write_ctrl_ready),
      .dma_write_ctrl_data_index(dma_write_ctrl_data_index),
      .compute_start(compute_start), .acc_done(acc_done)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic bit chance(input int pct);
      return int'($urandom % 100) < pct;
   endfunction

   // Inputs are driven and outputs sampled 1 ns after the edge
   task automatic tick();
      @(posedge clk);
      #1;
      if (compute_start)
         starts++;
      if (acc_done)
         dones++;
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
      end
   endtask

   task automatic finish_sim(input bit timed_out);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (!timed_out && errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s within %0d cycles", what, limit);
      finish_sim(1'b1);
   endtask

   //////////////////////////////////////////////////
   // DMA side models
   task automatic take_request(input bit is_write, input int index, input int words,
                               input int stall_pct);
      string       name;
      logic        v;
      logic [31:0] idx;
      logic [31:0] len;
      logic [2:0]  size;
      bit          seen;
      bit          taken;
      int          n;
      name  = is_write ? "dma_write_ctrl" : "dma_read_ctrl";
      seen  = 1'b0;
      taken = 1'b0;
      n     = 0;
      while (!taken)
      begin
         v    = is_write ? dma_write_ctrl_valid : dma_read_ctrl_valid;
         idx  = is_write ? dma_write_ctrl_data_index : dma_read_ctrl_data_index;
         len  = is_write ? dma_write_ctrl_data_length : dma_read_ctrl_data_length;
         size = is_write ? dma_write_ctrl_data_size : dma_read_ctrl_data_size;
         if (seen)
            check_value({name, "_valid"}, v, 1);   // Held until ready
         if (v)
         begin
            seen = 1'b1;
            check_value({name, "_data_index"}, idx, index);
            check_value({name, "_data_length"}, len, words);
            check_value({name, "_data_size"}, size, 2);
            taken = !chance(stall_pct);
         end
         if (is_write)
            dma_write_ctrl_ready = taken;
         else
            dma_read_ctrl_ready = taken;
         tick();
         dma_write_ctrl_ready = 1'b0;
         dma_read_ctrl_ready  = 1'b0;
         n++;
         if (!taken && n == limit)
            report_timeout({name, " request was not completed"});
      end
   endtask

   task automatic load_beats(input bit is_act, input int beats, input int gap_pct);
      logic [63:0] beat;
      bit          accepted;
      int          k;
      int          n;
      k = 0;
      n = 0;
      check_value("dma_read_chnl_ready", dma_read_chnl_ready, 1);
      while (k < beats)
      begin
         if (is_act)
            beat = {a_words[2*k+1], a_words[2*k]};
         else
            beat = {w_words[2*k+1], w_words[2*k]};
         dma_read_chnl_valid = !chance(gap_pct);
         dma_read_chnl_data  = dma_read_chnl_valid ? beat : {$urandom, $urandom};
         accepted = dma_read_chnl_valid && dma_read_chnl_ready;
         tick();
         n = accepted ? 0 : n + 1;
         if (accepted)
            k++;
         if (n == limit)
            report_timeout("a read channel beat was not accepted");
      end
      dma_read_chnl_valid = 1'b0;
      check_value("dma_read_chnl_ready", dma_read_chnl_ready, 0);
   endtask

   task automatic collect_results(input int stall_pct);
      bit accepted;
      int k;
      int n;
      k = 0;
      n = 0;
      while (k < wb_beats)
      begin
         dma_write_chnl_ready = !chance(stall_pct);
         accepted = dma_write_chnl_valid && dma_write_chnl_ready;
         if (dma_write_chnl_valid)
            check_value("dma_write_chnl_data", dma_write_chnl_data,
                        {r_words[2*k+1], r_words[2*k]});   // Same beat until taken
         tick();
         n = accepted ? 0 : n + 1;
         if (accepted)
            k++;
         if (n == limit)
            report_timeout("a write channel beat was not offered");
      end
      dma_write_chnl_ready = 1'b0;
      check_value("acc_done", acc_done, 1);
      check_value("dma_write_chnl_valid", dma_write_chnl_valid, 0);
      tick();
      check_value("acc_done", acc_done, 0);
   endtask

   //////////////////////////////////////////////////
   // Compute engine model
   task automatic run_engine(input logic [31:0] key);
      for (int j = 0; j < w_beats; j++)
      begin
         eng_w_addr0 = 16'(2*j);
         eng_w_addr1 = 16'(2*j + 1);
         eng_a_addr0 = 16'(2*(j % a_beats));
         eng_a_addr1 = 16'(2*(j % a_beats) + 1);
         tick();
         check_value("eng_w_rdata0", eng_w_rdata0, w_words[2*j]);
         check_value("eng_w_rdata1", eng_w_rdata1, w_words[2*j + 1]);
         check_value("eng_a_rdata0", eng_a_rdata0, a_words[2*(j % a_beats)]);
         check_value("eng_a_rdata1", eng_a_rdata1, a_words[2*(j % a_beats) + 1]);
      end
      for (int m = 0; m < 2*wb_beats; m++)
         r_words[m] = a_words[m] ^ key;
      for (int k = 0; k < wb_beats; k++)
      begin
         eng_a_addr0  = 16'(2*a_beats + 2*k);   // Right after the inputs
         eng_a_addr1  = 16'(2*a_beats + 2*k + 1);
         eng_a_we0    = 4'hf;
         eng_a_we1    = 4'hf;
         eng_a_wdata0 = r_words[2*k];
         eng_a_wdata1 = r_words[2*k + 1];
         tick();
      end
      eng_a_we0      = '0;
      eng_a_we1      = '0;
      compute_finish = 1'b1;
      tick();
      check_value("dma_write_ctrl_valid", dma_write_ctrl_valid, 1);
      compute_finish = 1'b0;
   endtask

   task automatic do_run(input int r);
      foreach (w_words[i])
         w_words[i] = $urandom;
      foreach (a_words[i])
         a_words[i] = $urandom;
      starts = 0;
      dones  = 0;
      repeat (3)
      begin
         tick();
         check_value("dma_read_ctrl_valid", dma_read_ctrl_valid, 0);
         check_value("acc_done", acc_done, 0);
      end
      conf_done = 1'b1;
      tick();
      conf_done = 1'b0;
      check_value("dma_read_ctrl_valid", dma_read_ctrl_valid, 1);
      take_request(1'b0, w_index, 2*w_beats, ctrl_stall[r]);
      load_beats(1'b0, w_beats, read_gap[r]);
      take_request(1'b0, a_index, 2*a_beats, ctrl_stall[r]);
      load_beats(1'b1, a_beats, read_gap[r]);
      check_value("compute_start", compute_start, 0);
      tick();
      check_value("compute_start", compute_start, 1);
      run_engine(result_key[r]);
      take_request(1'b1, wb_index, 2*wb_beats, ctrl_stall[r]);
      collect_results(wr_stall[r]);
      check_value("compute_start pulses", starts, 1);
      check_value("acc_done pulses", dones, 1);
   endtask

   initial
   begin
      void'($urandom(32'h64d93fc8));
      errors               = 0;
      checks               = 0;
      rst                  = 1'b0;
      conf_done            = 1'b0;
      compute_finish       = 1'b0;
      dma_read_ctrl_ready  = 1'b0;
      dma_read_chnl_valid  = 1'b0;
      dma_read_chnl_data   = '0;
      dma_write_ctrl_ready = 1'b0;
      dma_write_chnl_ready = 1'b0;
      eng_w_addr0          = '0;
      eng_w_addr1          = '0;
      eng_a_addr0          = '0;
      eng_a_addr1          = '0;
      eng_a_we0            = '0;
      eng_a_we1            = '0;
      eng_a_wdata0         = '0;
      eng_a_wdata1         = '0;
      repeat (8)
         @(posedge clk);
      #1;
      rst = 1'b1;
      check_value("dma_read_ctrl_valid", dma_read_ctrl_valid, 0);
      check_value("dma_write_ctrl_valid", dma_write_ctrl_valid, 0);
      check_value("dma_write_chnl_valid", dma_write_chnl_valid, 0);
      check_value("dma_read_chnl_ready", dma_read_chnl_ready, 0);
      check_value("compute_start", compute_start, 0);
      check_value("acc_done", acc_done, 0);
      for (int r = 0; r < n_runs; r++)
         do_run(r);
      check_value("assertion failures", dut0.u_fsm.u_assert.violations, 0);
      finish_sim(1'b0);
   end

endmodule

`default_nettype wire

// ==== build.f ====
design/acc_dma_pkg.sv
design/dual_port_sram.sv
design/dma_phase_fsm.sv
design/buffer_access_ctrl.sv
design/writeback_streamer.sv
design/acc_dma_top.sv
verif/acc_dma_assertions.sv
verif/tb_acc_dma.sv

// ==== Bender.yml ====
package:
  name: acc_dma

sources:
  - target: rtl
    files:
      - design/acc_dma_pkg.sv
      - design/dual_port_sram.sv
      - design/dma_phase_fsm.sv
      - design/buffer_access_ctrl.sv
      - design/writeback_streamer.sv
      - design/acc_dma_top.sv
  - target: test
    files:
      - verif/acc_dma_assertions.sv
      - verif/tb_acc_dma.sv
